/* flist.f */
logic/issue_pkg.sv
logic/dispatch_decode.sv
logic/reservation_station.sv
logic/issue_select.sv
logic/alu_execute.sv
logic/phys_reg_file.sv
logic/result_writeback.sv
logic/issue_core.sv
verification/tb_clock_gen.sv
verification/issue_core_tb.sv

/* logic/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             issue_valid,
    input  issue_pkg::alu_op_t               issue_op,
    input  logic [issue_pkg::tag_bits-1:0]   issue_dest,
    input  logic [issue_pkg::data_width-1:0] read_data1,
    input  logic [issue_pkg::data_width-1:0] read_data2,
    output logic                             alu_valid,
    output logic [issue_pkg::tag_bits-1:0]   alu_dest,
    output logic [issue_pkg::data_width-1:0] alu_value
);
    import issue_pkg::*;

    logic [data_width-1:0] result;

    always_comb begin
        case (issue_op)
            op_add:  result = read_data1 + read_data2;   // Wraps at 16 bits
            op_sub:  result = read_data1 - read_data2;
            op_and:  result = read_data1 & read_data2;
            op_or:   result = read_data1 | read_data2;
            op_xor:  result = read_data1 ^ read_data2;
            op_sll:  result = read_data1 << read_data2[3:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        alu_dest  <= issue_dest;
        alu_value <= result;
    end

endmodule

/* logic/dispatch_decode.sv */
`timescale 1ns/1ps

module dispatch_decode (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              dispatch_req,
    input  logic [issue_pkg::opcode_bits-1:0] dispatch_opcode,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_src1,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_src2,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_dest,
    input  logic                              src1_ready,
    input  logic                              src2_ready,
    input  logic [issue_pkg::rs_count_bits-1:0] rs_free_count,
    output logic                              dispatch_ack,
    output logic                              dispatch_illegal,
    output logic                              alloc_valid,
    output issue_pkg::alu_op_t                alloc_op,
    output logic [issue_pkg::tag_bits-1:0]    alloc_src1,
    output logic [issue_pkg::tag_bits-1:0]    alloc_src2,
    output logic                              alloc_src1_ready,
    output logic                              alloc_src2_ready,
    output logic [issue_pkg::tag_bits-1:0]    alloc_dest,
    output logic                              claim_valid,
    output logic [issue_pkg::tag_bits-1:0]    claim_tag
);
    import issue_pkg::*;

    dispatch_state_t state;
    logic legal;

    always_comb begin
        legal    = 1'b1;
        alloc_op = op_add;
        case (dispatch_opcode)
            raw_add: alloc_op = op_add;
            raw_sub: alloc_op = op_sub;
            raw_and: alloc_op = op_and;
            raw_or:  alloc_op = op_or;
            raw_xor: alloc_op = op_xor;
            raw_sll: alloc_op = op_sll;
            default: legal = 1'b0;
        endcase
    end

    // Take a legal instruction only when the station has room
    assign alloc_valid = (state == disp_idle) && dispatch_req && legal &&
                         (rs_free_count != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= disp_idle;
        end else begin
            case (state)
                disp_idle: begin
                    if (dispatch_req && !legal) begin
                        state <= disp_drop;
                    end else if (alloc_valid) begin
                        state <= disp_ack;
                    end
                end
                default: begin
                    if (!dispatch_req) state <= disp_idle;  // Ack drops after req low
                end
            endcase
        end
    end

    assign dispatch_ack     = (state != disp_idle);
    assign dispatch_illegal = (state == disp_drop);

    assign alloc_src1       = dispatch_src1;
    assign alloc_src2       = dispatch_src2;
    assign alloc_src1_ready = src1_ready;   // Scoreboard read, broadcast forwarded
    assign alloc_src2_ready = src2_ready;
    assign alloc_dest       = dispatch_dest;

    // Destination goes not ready in the allocation cycle
    assign claim_valid = alloc_valid;
    assign claim_tag   = dispatch_dest;

endmodule

/* logic/issue_core.sv */
`timescale 1ns/1ps

module issue_core (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              dispatch_req,
    input  logic [issue_pkg::opcode_bits-1:0] dispatch_opcode,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_src1,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_src2,
    input  logic [issue_pkg::tag_bits-1:0]    dispatch_dest,
    output logic                              dispatch_ack,
    output logic                              dispatch_illegal,
    output logic                              result_valid,
    output logic [issue_pkg::tag_bits-1:0]    result_tag,
    output logic [issue_pkg::data_width-1:0]  result_value
);
    import issue_pkg::*;

    // Decode to station and scoreboard
    logic                alloc_valid;
    alu_op_t             alloc_op;
    logic [tag_bits-1:0] alloc_src1;
    logic [tag_bits-1:0] alloc_src2;
    logic                alloc_src1_ready;
    logic                alloc_src2_ready;
    logic [tag_bits-1:0] alloc_dest;
    logic                claim_valid;
    logic [tag_bits-1:0] claim_tag;
    logic                src1_ready;
    logic                src2_ready;

    // Station and selector
    logic [rs_size-1:0]       entry_valid;
    logic [rs_size-1:0]       entry_ready;
    logic                     issue_valid;
    logic [rs_index_bits-1:0] issue_index;
    logic [rs_count_bits-1:0] rs_free_count;
    alu_op_t                  issue_op;
    logic [tag_bits-1:0]      issue_src1;
    logic [tag_bits-1:0]      issue_src2;
    logic [tag_bits-1:0]      issue_dest;

    // Execute and broadcast
    logic [data_width-1:0] read_data1;
    logic [data_width-1:0] read_data2;
    logic                  alu_valid;
    logic [tag_bits-1:0]   alu_dest;
    logic [data_width-1:0] alu_value;
    logic                  cdb_valid;
    logic [tag_bits-1:0]   cdb_tag;
    logic [data_width-1:0] cdb_value;

    dispatch_decode decode_i (
        .clock(clock), .reset(reset),
        .dispatch_req(dispatch_req), .dispatch_opcode(dispatch_opcode),
        .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
        .dispatch_dest(dispatch_dest),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .rs_free_count(rs_free_count),
        .dispatch_ack(dispatch_ack), .dispatch_illegal(dispatch_illegal),
        .alloc_valid(alloc_valid), .alloc_op(alloc_op),
        .alloc_src1(alloc_src1), .alloc_src2(alloc_src2),
        .alloc_src1_ready(alloc_src1_ready), .alloc_src2_ready(alloc_src2_ready),
        .alloc_dest(alloc_dest),
        .claim_valid(claim_valid), .claim_tag(claim_tag)
    );

    reservation_station rs_i (
        .clock(clock), .reset(reset),
        .alloc_valid(alloc_valid), .alloc_op(alloc_op),
        .alloc_src1(alloc_src1), .alloc_src2(alloc_src2),
        .alloc_src1_ready(alloc_src1_ready), .alloc_src2_ready(alloc_src2_ready),
        .alloc_dest(alloc_dest),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .issue_valid(issue_valid), .issue_index(issue_index),
        .entry_valid(entry_valid), .entry_ready(entry_ready),
        .issue_op(issue_op), .issue_src1(issue_src1),
        .issue_src2(issue_src2), .issue_dest(issue_dest)
    );

    issue_select select_i (
        .entry_valid(entry_valid), .entry_ready(entry_ready),
        .issue_valid(issue_valid), .issue_index(issue_index),
        .rs_free_count(rs_free_count)
    );

    // Operand ports follow the issued entry, ready ports follow dispatch
    phys_reg_file prf_i (
        .clock(clock), .reset(reset),
        .read_src1(issue_src1), .read_src2(issue_src2),
        .ready_src1(dispatch_src1), .ready_src2(dispatch_src2),
        .claim_valid(claim_valid), .claim_tag(claim_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .read_data1(read_data1), .read_data2(read_data2),
        .src1_ready(src1_ready), .src2_ready(src2_ready)
    );

    alu_execute alu_i (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_dest(issue_dest),
        .read_data1(read_data1), .read_data2(read_data2),
        .alu_valid(alu_valid), .alu_dest(alu_dest), .alu_value(alu_value)
    );

    result_writeback wb_i (
        .clock(clock), .reset(reset),
        .alu_valid(alu_valid), .alu_dest(alu_dest), .alu_value(alu_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value)
    );

endmodule

/* logic/issue_pkg.sv */
package issue_pkg;

    localparam int data_width     = 16;   // Register value width
    localparam int phys_reg_count = 32;
    localparam int tag_bits       = 5;    // Physical register tag
    localparam int rs_size        = 8;    // Reservation station entries
    localparam int rs_index_bits  = 3;
    localparam int rs_count_bits  = 4;    // Free count runs 0 to 8
    localparam int opcode_bits    = 3;

    // Raw dispatch opcodes, codes 6 and 7 are illegal
    localparam logic [opcode_bits-1:0] raw_add = 3'd0;
    localparam logic [opcode_bits-1:0] raw_sub = 3'd1;
    localparam logic [opcode_bits-1:0] raw_and = 3'd2;
    localparam logic [opcode_bits-1:0] raw_or  = 3'd3;
    localparam logic [opcode_bits-1:0] raw_xor = 3'd4;
    localparam logic [opcode_bits-1:0] raw_sll = 3'd5;

    // Operation carried through the station to the ALU
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll   // Source 1 shifted left by low four bits of source 2
    } alu_op_t;

    // Dispatch handshake state
    typedef enum logic [1:0] {
        disp_idle,
        disp_ack,
        disp_drop   // Illegal opcode acknowledged, nothing written
    } dispatch_state_t;

endpackage

/* logic/issue_select.sv */
`timescale 1ns/1ps

module issue_select (
    input  logic [issue_pkg::rs_size-1:0]       entry_valid,
    input  logic [issue_pkg::rs_size-1:0]       entry_ready,
    output logic                                issue_valid,
    output logic [issue_pkg::rs_index_bits-1:0] issue_index,
    output logic [issue_pkg::rs_count_bits-1:0] rs_free_count
);
    import issue_pkg::*;

    logic [rs_size-1:0] candidates;

    assign candidates = entry_valid & entry_ready;

    // Priority encoder, lowest index first
    always_comb begin
        issue_valid = 1'b0;
        issue_index = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (candidates[i]) begin
                issue_valid = 1'b1;
                issue_index = rs_index_bits'(i);
            end
        end
    end

    // Count of empty slots for dispatch back-pressure
    always_comb begin
        rs_free_count = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (!entry_valid[i]) rs_free_count = rs_free_count + rs_count_bits'(1);
        end
    end

endmodule

/* logic/phys_reg_file.sv */
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [issue_pkg::tag_bits-1:0]   read_src1,
    input  logic [issue_pkg::tag_bits-1:0]   read_src2,
    input  logic [issue_pkg::tag_bits-1:0]   ready_src1,
    input  logic [issue_pkg::tag_bits-1:0]   ready_src2,
    input  logic                             claim_valid,
    input  logic [issue_pkg::tag_bits-1:0]   claim_tag,
    input  logic                             cdb_valid,
    input  logic [issue_pkg::tag_bits-1:0]   cdb_tag,
    input  logic [issue_pkg::data_width-1:0] cdb_value,
    output logic [issue_pkg::data_width-1:0] read_data1,
    output logic [issue_pkg::data_width-1:0] read_data2,
    output logic                             src1_ready,
    output logic                             src2_ready
);
    import issue_pkg::*;

    logic [data_width-1:0]     value_q [phys_reg_count];
    logic [phys_reg_count-1:0] ready_q;   // Scoreboard

    always_ff @(posedge clock) begin
        if (reset) begin
            // Register p starts at value p
            for (int p = 0; p < phys_reg_count; p++) begin
                value_q[p] <= data_width'(p);
            end
            ready_q <= '1;
        end else begin
            if (claim_valid) ready_q[claim_tag] <= 1'b0;
            if (cdb_valid) begin
                value_q[cdb_tag] <= cdb_value;
                ready_q[cdb_tag] <= 1'b1;
            end
        end
    end

    // Operand reads for the issued entry
    assign read_data1 = value_q[read_src1];
    assign read_data2 = value_q[read_src2];

    // Decode readiness with the current broadcast forwarded
    assign src1_ready = ready_q[ready_src1] | (cdb_valid && (cdb_tag == ready_src1));
    assign src2_ready = ready_q[ready_src2] | (cdb_valid && (cdb_tag == ready_src2));

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                alloc_valid,
    input  issue_pkg::alu_op_t                  alloc_op,
    input  logic [issue_pkg::tag_bits-1:0]      alloc_src1,
    input  logic [issue_pkg::tag_bits-1:0]      alloc_src2,
    input  logic                                alloc_src1_ready,
    input  logic                                alloc_src2_ready,
    input  logic [issue_pkg::tag_bits-1:0]      alloc_dest,
    input  logic                                cdb_valid,
    input  logic [issue_pkg::tag_bits-1:0]      cdb_tag,
    input  logic                                issue_valid,
    input  logic [issue_pkg::rs_index_bits-1:0] issue_index,
    output logic [issue_pkg::rs_size-1:0]       entry_valid,
    output logic [issue_pkg::rs_size-1:0]       entry_ready,
    output issue_pkg::alu_op_t                  issue_op,
    output logic [issue_pkg::tag_bits-1:0]      issue_src1,
    output logic [issue_pkg::tag_bits-1:0]      issue_src2,
    output logic [issue_pkg::tag_bits-1:0]      issue_dest
);
    import issue_pkg::*;

    logic [rs_size-1:0]  valid_q;
    logic [rs_size-1:0]  rdy1_q;
    logic [rs_size-1:0]  rdy2_q;
    alu_op_t             op_q   [rs_size];
    logic [tag_bits-1:0] src1_q [rs_size];
    logic [tag_bits-1:0] src2_q [rs_size];
    logic [tag_bits-1:0] dest_q [rs_size];

    logic [rs_index_bits-1:0] alloc_slot;
    logic                     wake1;
    logic                     wake2;

    // Lowest free slot, scanned from the top so index 0 wins
    always_comb begin
        alloc_slot = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!valid_q[i]) alloc_slot = rs_index_bits'(i);
        end
    end

    // Broadcast in the allocation cycle wakes the new entry too
    assign wake1 = cdb_valid && (cdb_tag == alloc_src1);
    assign wake2 = cdb_valid && (cdb_tag == alloc_src2);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (issue_valid) valid_q[issue_index] <= 1'b0;
            if (alloc_valid) valid_q[alloc_slot] <= 1'b1;  // Slot is free, never the issued one
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_size; i++) begin
            // Tag CAM on every stored source
            if (cdb_valid && (src1_q[i] == cdb_tag)) rdy1_q[i] <= 1'b1;
            if (cdb_valid && (src2_q[i] == cdb_tag)) rdy2_q[i] <= 1'b1;
        end
        if (alloc_valid) begin
            op_q[alloc_slot]   <= alloc_op;
            src1_q[alloc_slot] <= alloc_src1;
            src2_q[alloc_slot] <= alloc_src2;
            dest_q[alloc_slot] <= alloc_dest;
            rdy1_q[alloc_slot] <= alloc_src1_ready | wake1;
            rdy2_q[alloc_slot] <= alloc_src2_ready | wake2;
        end
    end

    assign entry_valid = valid_q;
    assign entry_ready = valid_q & rdy1_q & rdy2_q;

    // Selected entry fields for the register file and ALU
    assign issue_op   = op_q[issue_index];
    assign issue_src1 = src1_q[issue_index];
    assign issue_src2 = src2_q[issue_index];
    assign issue_dest = dest_q[issue_index];

endmodule

/* logic/result_writeback.sv */
`timescale 1ns/1ps

module result_writeback (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             alu_valid,
    input  logic [issue_pkg::tag_bits-1:0]   alu_dest,
    input  logic [issue_pkg::data_width-1:0] alu_value,
    output logic                             cdb_valid,
    output logic [issue_pkg::tag_bits-1:0]   cdb_tag,
    output logic [issue_pkg::data_width-1:0] cdb_value,
    output logic                             result_valid,
    output logic [issue_pkg::tag_bits-1:0]   result_tag,
    output logic [issue_pkg::data_width-1:0] result_value
);
    import issue_pkg::*;

    logic                  valid_q;
    logic [tag_bits-1:0]   tag_q;
    logic [data_width-1:0] value_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= alu_valid;
        end
    end

    always_ff @(posedge clock) begin
        tag_q   <= alu_dest;
        value_q <= alu_value;
    end

    // One registered copy feeds both the broadcast and the port
    assign cdb_valid    = valid_q;
    assign cdb_tag      = tag_q;
    assign cdb_value    = value_q;
    assign result_valid = valid_q;
    assign result_tag   = tag_q;
    assign result_value = value_q;

endmodule

/* verification/issue_cases.txt */
# opcode src1 src2 dest in decimal, then the expected value in hex
# or the word illegal when the opcode has no operation
# independent operations on reset values
0 3 4 8 0007
1 2 5 9 fffd
2 6 3 10 0002
3 5 2 11 0007
4 7 2 12 0005
5 3 7 13 0180
# dependency chain, each link needs the previous result
5 7 9 14 e000
0 14 14 15 c000
1 15 8 16 bff9
4 16 13 17 be79
3 17 10 18 be7b
# illegal opcodes, their destinations keep reset values
6 1 2 19 illegal
7 3 4 20 illegal
0 19 20 21 0027
# chain tail followed by nine dependents
1 18 21 22 be54
0 22 1 23 be55
1 22 2 24 be52
2 22 15 25 8000
3 22 3 26 be57
4 22 22 27 0000
5 22 4 28 e540
0 22 14 29 9e54
1 5 22 30 41b1
2 22 17 31 be50

/* verification/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb;
    import issue_pkg::*;

    localparam int max_cases  = 64;
    localparam int wait_limit = 200;   // Cycles allowed for any single wait

    logic                   clock;
    logic                   reset;
    logic                   dispatch_req;
    logic [opcode_bits-1:0] dispatch_opcode;
    logic [tag_bits-1:0]    dispatch_src1;
    logic [tag_bits-1:0]    dispatch_src2;
    logic [tag_bits-1:0]    dispatch_dest;
    logic                   dispatch_ack;
    logic                   dispatch_illegal;
    logic                   result_valid;
    logic [tag_bits-1:0]    result_tag;
    logic [data_width-1:0]  result_value;

    // Case table loaded from the data file
    int                     case_count;
    int                     legal_count;
    logic [opcode_bits-1:0] case_op       [max_cases];
    logic [tag_bits-1:0]    case_src1     [max_cases];
    logic [tag_bits-1:0]    case_src2     [max_cases];
    logic [tag_bits-1:0]    case_dest     [max_cases];
    logic [data_width-1:0]  case_expected [max_cases];
    bit                     case_illegal  [max_cases];
    bit                     case_failed   [max_cases];

    // Result strobes collected by destination tag
    int                     strobe_count [phys_reg_count];
    logic [data_width-1:0]  strobe_value [phys_reg_count];
    time                    strobe_time  [phys_reg_count];
    int                     strobe_total;
    int                     error_count;
    bit                     timed_out;
    logic                   prev_req;
    logic                   prev_ack;

    tb_clock_gen clock_gen_i (.clock(clock), .reset(reset));

    issue_core dut_i (
        .clock(clock), .reset(reset),
        .dispatch_req(dispatch_req), .dispatch_opcode(dispatch_opcode),
        .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
        .dispatch_dest(dispatch_dest),
        .dispatch_ack(dispatch_ack), .dispatch_illegal(dispatch_illegal),
        .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value)
    );

    task automatic record_error(input int idx);
        error_count++;
        if (idx >= 0) case_failed[idx] = 1'b1;
    endtask

    // Edge samples hold the values settled during the cycle just ended
    always @(posedge clock) begin
        if (!reset) begin
            assert (!(dispatch_ack && !prev_ack && !prev_req)) else begin
                $display("Error at %0t: dispatch_ack rose while dispatch_req was low", $time);
                record_error(-1);
            end
            assert (!(!dispatch_ack && prev_ack && prev_req)) else begin
                $display("Error at %0t: dispatch_ack fell while dispatch_req was high", $time);
                record_error(-1);
            end
            if (result_valid) begin
                strobe_count[result_tag]++;
                strobe_value[result_tag] = result_value;
                strobe_time[result_tag]  = $time;
                strobe_total++;
            end
        end
        prev_req = dispatch_req;
        prev_ack = dispatch_ack;
    end

    task automatic load_cases();
        int               fd;
        int               fields;
        int               op;
        int               src1;
        int               src2;
        int               dest;
        logic [31:0]      value;
        logic [8*128-1:0] line;
        fd = $fopen("verification/issue_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Error: the case file verification/issue_cases.txt cannot be opened");
            record_error(-1);
        end
        if (fd == 0) return;
        while ($fgets(line, fd) != 0 && case_count < max_cases) begin
            fields = $sscanf(line, "%d %d %d %d %h", op, src1, src2, dest, value);
            if (fields >= 4) begin   // Comment and blank lines parse fewer fields
                case_op[case_count]       = opcode_bits'(op);
                case_src1[case_count]     = tag_bits'(src1);
                case_src2[case_count]     = tag_bits'(src2);
                case_dest[case_count]     = tag_bits'(dest);
                case_expected[case_count] = data_width'(value);
                case_illegal[case_count]  = (fields == 4);   // Marker word is not hex
                if (fields == 5) legal_count++;
                case_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_ack_level(input logic level, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
            if (dispatch_ack === level) ok = 1'b1;
        end
    endtask

    // Full four-phase transfer, starting at the current edge
    task automatic dispatch_case(input int idx);
        bit ok;
        dispatch_opcode <= case_op[idx];
        dispatch_src1   <= case_src1[idx];
        dispatch_src2   <= case_src2[idx];
        dispatch_dest   <= case_dest[idx];
        dispatch_req    <= 1'b1;
        wait_ack_level(1'b1, ok);
        assert (ok) else begin
            $display("Error at %0t: case %0d was never acknowledged", $time, idx);
            record_error(idx);
            timed_out = 1'b1;
        end
        if (!ok) return;
        assert (dispatch_illegal == case_illegal[idx]) else begin
            $display("Mismatch at %0t: dispatch_illegal got %b expected %b",
                     $time, dispatch_illegal, case_illegal[idx]);
            record_error(idx);
        end
        dispatch_req <= 1'b0;
        wait_ack_level(1'b0, ok);
        assert (ok) else begin
            $display("Error at %0t: ack of case %0d never went low", $time, idx);
            record_error(idx);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_case(input int idx);
        logic [tag_bits-1:0] tag;
        tag = case_dest[idx];
        if (case_illegal[idx]) begin
            assert (strobe_count[tag] == 0) else begin
                $display("Error: illegal case %0d still produced a result for tag %0d", idx, tag);
                record_error(idx);
            end
        end else begin
            assert (strobe_count[tag] == 1) else begin
                $display("Error: case %0d saw %0d result strobes for tag %0d",
                         idx, strobe_count[tag], tag);
                record_error(idx);
            end
            assert (strobe_count[tag] == 0 || strobe_value[tag] == case_expected[idx]) else begin
                $display("Mismatch at %0t: result_value for tag %0d got %h expected %h",
                         strobe_time[tag], tag, strobe_value[tag], case_expected[idx]);
                record_error(idx);
            end
        end
        $display("case %0d op %0d p%0d <- p%0d, p%0d: %s", idx, case_op[idx], tag,
                 case_src1[idx], case_src2[idx], case_failed[idx] ? "FAILED" : "passed");
    endtask

    initial begin
        int cycles;
        int passed;
        dispatch_req    = 1'b0;
        dispatch_opcode = '0;
        dispatch_src1   = '0;
        dispatch_src2   = '0;
        dispatch_dest   = '0;
        case_count      = 0;
        legal_count     = 0;
        strobe_total    = 0;
        error_count     = 0;
        timed_out       = 1'b0;
        passed          = 0;
        for (int t = 0; t < phys_reg_count; t++) strobe_count[t] = 0;
        for (int i = 0; i < max_cases; i++) case_failed[i] = 1'b0;
        load_cases();
        assert (case_count > 0) else begin
            $display("Error: no cases were loaded");
            record_error(-1);
        end
        cycles = 0;
        @(posedge clock);
        while (reset && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        for (int i = 0; i < case_count && !timed_out; i++) dispatch_case(i);
        cycles = 0;
        while (!timed_out && strobe_total < legal_count && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        assert (timed_out || strobe_total >= legal_count) else begin
            $display("Error: only %0d of %0d results arrived", strobe_total, legal_count);
            record_error(-1);
            timed_out = 1'b1;
        end
        repeat (10) @(posedge clock);   // Catch any late or stray strobe
        for (int i = 0; i < case_count; i++) begin
            check_case(i);
            if (!case_failed[i]) passed++;
        end
        assert (strobe_total == legal_count) else begin
            $display("Error: %0d result strobes for %0d legal cases", strobe_total, legal_count);
            record_error(-1);
        end
        $display("%0d cases passed, %0d failed, %0d errors", passed, case_count - passed,
                 error_count);
        if (error_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns period
    end

    // Reset held for the first eight rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

endmodule
